// ==== common/rv_dec_pkg.sv ====
package rv_dec_pkg;

localparam int XLEN   = 32;
localparam int REG_AW = 5;

// major opcodes, RV32I base
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;

// funct3 of the alu group, shared by op and op-imm
localparam logic [2:0] F3_ADD  = 3'b000;
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;
localparam logic [2:0] F3_OR   = 3'b110;
localparam logic [2:0] F3_AND  = 3'b111;

// queue depths and credits
localparam int IN_DEPTH    = 4;
localparam int OUT_CREDITS = 2;
localparam int OUT_DEPTH   = 2;
localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

typedef enum logic [5:0] {
    OP_ILLEGAL,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
} op_e;

typedef struct packed {
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] pc;
} fetch_entry_t;

typedef struct packed {
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc;
    logic              jump_en;
    logic [XLEN-1:0]   jump_target;
    logic              is_c;
} dec_op_t;

endpackage

// ==== source/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

payload_t                    mem [DEPTH];
logic [$clog2(DEPTH)-1:0]    rd_ptr;
logic [$clog2(DEPTH)-1:0]    wr_ptr;
logic [$clog2(DEPTH+1)-1:0]  count;
logic                        do_push;
logic                        do_pop;

assign do_push = push && !full;
assign do_pop  = pop && !empty;
assign empty   = (count == '0);
assign full    = (int'(count) == DEPTH);
assign head    = mem[rd_ptr];

always_ff @(posedge clk) begin
    if (rst) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push)
            wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
        if (do_pop)
            rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (do_push)
        mem[wr_ptr] <= push_data;
end

endmodule

// ==== decode/std_decoder.sv ====
`timescale 1ns/1ps

module std_decoder
    import rv_dec_pkg::*;
(
    input  logic [XLEN-1:0]   ins,
    output op_e               op,
    output logic [REG_AW-1:0] rd,
    output logic [REG_AW-1:0] rs1,
    output logic [REG_AW-1:0] rs2,
    output logic [XLEN-1:0]   imm
);

typedef enum logic [2:0] {
    FMT_NONE, FMT_R, FMT_I, FMT_SH, FMT_S, FMT_B, FMT_U, FMT_J
} fmt_e;

logic [6:0] opcode;
logic [2:0] funct3;
logic       alt;
fmt_e       fmt;

assign opcode = ins[6:0];
assign funct3 = ins[14:12];
// funct7 bit 5, sub and arithmetic shifts
assign alt    = ins[30];

//////////////////////////////
// op kind and format
//////////////////////////////
always_comb begin
    op  = OP_ILLEGAL;
    fmt = FMT_NONE;
    case (opcode)
        OPC_LUI: begin
            op  = OP_LUI;
            fmt = FMT_U;
        end
        OPC_AUIPC: begin
            op  = OP_AUIPC;
            fmt = FMT_U;
        end
        OPC_JAL: begin
            op  = OP_JAL;
            fmt = FMT_J;
        end
        OPC_JALR: begin
            if (funct3 == 3'b000) begin
                op  = OP_JALR;
                fmt = FMT_I;
            end
        end
        OPC_BRANCH: begin
            fmt = FMT_B;
            case (funct3)
                3'b000:  op = OP_BEQ;
                3'b001:  op = OP_BNE;
                3'b100:  op = OP_BLT;
                3'b101:  op = OP_BGE;
                3'b110:  op = OP_BLTU;
                3'b111:  op = OP_BGEU;
                default: fmt = FMT_NONE;
            endcase
        end
        OPC_LOAD: begin
            fmt = FMT_I;
            case (funct3)
                3'b000:  op = OP_LB;
                3'b001:  op = OP_LH;
                3'b010:  op = OP_LW;
                3'b100:  op = OP_LBU;
                3'b101:  op = OP_LHU;
                default: fmt = FMT_NONE;
            endcase
        end
        OPC_STORE: begin
            fmt = FMT_S;
            case (funct3)
                3'b000:  op = OP_SB;
                3'b001:  op = OP_SH;
                3'b010:  op = OP_SW;
                default: fmt = FMT_NONE;
            endcase
        end
        OPC_OP_IMM: begin
            fmt = FMT_I;
            case (funct3)
                F3_ADD:  op = OP_ADDI;
                F3_SLT:  op = OP_SLTI;
                F3_SLTU: op = OP_SLTIU;
                F3_XOR:  op = OP_XORI;
                F3_OR:   op = OP_ORI;
                F3_AND:  op = OP_ANDI;
                F3_SLL: begin
                    op  = OP_SLLI;
                    fmt = FMT_SH;
                end
                F3_SR: begin
                    op  = alt ? OP_SRAI : OP_SRLI;
                    fmt = FMT_SH;
                end
            endcase
        end
        OPC_OP: begin
            fmt = FMT_R;
            case (funct3)
                F3_ADD:  op = alt ? OP_SUB : OP_ADD;
                F3_SLL:  op = OP_SLL;
                F3_SLT:  op = OP_SLT;
                F3_SLTU: op = OP_SLTU;
                F3_XOR:  op = OP_XOR;
                F3_SR:   op = alt ? OP_SRA : OP_SRL;
                F3_OR:   op = OP_OR;
                F3_AND:  op = OP_AND;
            endcase
        end
        default: ;
    endcase
end

//////////////////////////////
// register fields and imm
//////////////////////////////
always_comb begin
    rd  = '0;
    rs1 = '0;
    rs2 = '0;
    imm = '0;
    case (fmt)
        FMT_R: begin
            rd  = ins[11:7];
            rs1 = ins[19:15];
            rs2 = ins[24:20];
        end
        FMT_I: begin
            rd  = ins[11:7];
            rs1 = ins[19:15];
            imm = {{20{ins[31]}}, ins[31:20]};
        end
        FMT_SH: begin
            rd  = ins[11:7];
            rs1 = ins[19:15];
            imm = {27'b0, ins[24:20]};
        end
        FMT_S: begin
            rs1 = ins[19:15];
            rs2 = ins[24:20];
            imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        end
        FMT_B: begin
            rs1 = ins[19:15];
            rs2 = ins[24:20];
            imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        FMT_U: begin
            rd  = ins[11:7];
            imm = {ins[31:12], 12'b0};
        end
        FMT_J: begin
            rd  = ins[11:7];
            imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: ;
    endcase
end

endmodule

// ==== decode/c_decoder.sv ====
`timescale 1ns/1ps

module c_decoder
    import rv_dec_pkg::*;
(
    input  logic [15:0]       ins,
    output op_e               op,
    output logic [REG_AW-1:0] rd,
    output logic [REG_AW-1:0] rs1,
    output logic [REG_AW-1:0] rs2,
    output logic [XLEN-1:0]   imm
);

logic [1:0]        quad;
logic [2:0]        funct3;
logic [REG_AW-1:0] rd_full;
// 3-bit fields map onto x8..x15
logic [REG_AW-1:0] rd_p;
logic [REG_AW-1:0] rs1_p;

logic [XLEN-1:0]   imm_4spn;
logic [XLEN-1:0]   imm_lsw;
logic [XLEN-1:0]   imm_6;
logic [XLEN-1:0]   imm_shamt;
logic [XLEN-1:0]   imm_j;
logic [XLEN-1:0]   imm_b;
logic [XLEN-1:0]   imm_16sp;
logic [XLEN-1:0]   imm_lui;

assign quad    = ins[1:0];
assign funct3  = ins[15:13];
assign rd_full = ins[11:7];
assign rd_p    = {2'b01, ins[4:2]};
assign rs1_p   = {2'b01, ins[9:7]};

//////////////////////////////
// compressed immediates
//////////////////////////////
assign imm_4spn  = {22'b0, ins[10:7], ins[12:11], ins[5], ins[6], 2'b00};
assign imm_lsw   = {25'b0, ins[5], ins[12:10], ins[6], 2'b00};
assign imm_6     = {{26{ins[12]}}, ins[12], ins[6:2]};
assign imm_shamt = {27'b0, ins[6:2]};
assign imm_j     = {{20{ins[12]}}, ins[12], ins[8], ins[10:9], ins[6], ins[7], ins[2],
                    ins[11], ins[5:3], 1'b0};
assign imm_b     = {{23{ins[12]}}, ins[12], ins[6:5], ins[2], ins[11:10], ins[4:3], 1'b0};
assign imm_16sp  = {{22{ins[12]}}, ins[12], ins[4:3], ins[5], ins[2], ins[6], 4'b0};
assign imm_lui   = {{14{ins[12]}}, ins[12], ins[6:2], 12'b0};

always_comb begin
    op  = OP_ILLEGAL;
    rd  = '0;
    rs1 = '0;
    rs2 = '0;
    imm = '0;
    if (quad == 2'b00) begin
        case (funct3)
            3'b000: begin
                // zero nzuimm is reserved, this also rejects the all-zero halfword
                if (imm_4spn != '0) begin
                    op  = OP_ADDI;
                    rd  = rd_p;
                    rs1 = 5'd2;
                    imm = imm_4spn;
                end
            end
            3'b010: begin
                op  = OP_LW;
                rd  = rd_p;
                rs1 = rs1_p;
                imm = imm_lsw;
            end
            3'b110: begin
                op  = OP_SW;
                rs1 = rs1_p;
                rs2 = rd_p;
                imm = imm_lsw;
            end
            default: ;
        endcase
    end else if (quad == 2'b01) begin
        case (funct3)
            3'b000: begin
                op  = OP_ADDI;
                rd  = rd_full;
                rs1 = rd_full;
                imm = imm_6;
            end
            3'b001: begin
                op  = OP_JAL;
                rd  = 5'd1;
                imm = imm_j;
            end
            3'b010: begin
                op  = OP_ADDI;
                rd  = rd_full;
                imm = imm_6;
            end
            3'b011: begin
                // rd x2 selects addi16sp, any other nonzero rd is lui
                if (rd_full == 5'd2 && imm_16sp != '0) begin
                    op  = OP_ADDI;
                    rd  = 5'd2;
                    rs1 = 5'd2;
                    imm = imm_16sp;
                end else if (rd_full != 5'd0 && rd_full != 5'd2 && imm_lui != '0) begin
                    op  = OP_LUI;
                    rd  = rd_full;
                    imm = imm_lui;
                end
            end
            3'b100: begin
                rd  = rs1_p;
                rs1 = rs1_p;
                case (ins[11:10])
                    2'b00, 2'b01: begin
                        if (!ins[12]) begin
                            op  = ins[10] ? OP_SRAI : OP_SRLI;
                            imm = imm_shamt;
                        end
                    end
                    2'b10: begin
                        op  = OP_ANDI;
                        imm = imm_6;
                    end
                    default: begin
                        if (!ins[12]) begin
                            rs2 = rd_p;
                            case (ins[6:5])
                                2'b00:   op = OP_SUB;
                                2'b01:   op = OP_XOR;
                                2'b10:   op = OP_OR;
                                default: op = OP_AND;
                            endcase
                        end
                    end
                endcase
                if (op == OP_ILLEGAL) begin
                    rd  = '0;
                    rs1 = '0;
                end
            end
            3'b101: begin
                op  = OP_JAL;
                imm = imm_j;
            end
            default: begin
                // beqz and bnez compare against x0
                op  = funct3[0] ? OP_BNE : OP_BEQ;
                rs1 = rs1_p;
                imm = imm_b;
            end
        endcase
    end
end

endmodule

// ==== decode/decode_core.sv ====
`timescale 1ns/1ps

module decode_core
    import rv_dec_pkg::*;
(
    input  fetch_entry_t entry,
    output dec_op_t      result
);

op_e               std_op;
logic [REG_AW-1:0] std_rd;
logic [REG_AW-1:0] std_rs1;
logic [REG_AW-1:0] std_rs2;
logic [XLEN-1:0]   std_imm;
op_e               c_op;
logic [REG_AW-1:0] c_rd;
logic [REG_AW-1:0] c_rs1;
logic [REG_AW-1:0] c_rs2;
logic [XLEN-1:0]   c_imm;
logic              is_c;

// anything but 11 in the low bits is a 16-bit word
assign is_c = (entry.ins[1:0] != 2'b11);

std_decoder std_dec_i (
    .ins (entry.ins),
    .op  (std_op),
    .rd  (std_rd),
    .rs1 (std_rs1),
    .rs2 (std_rs2),
    .imm (std_imm)
);

c_decoder c_dec_i (
    .ins (entry.ins[15:0]),
    .op  (c_op),
    .rd  (c_rd),
    .rs1 (c_rs1),
    .rs2 (c_rs2),
    .imm (c_imm)
);

always_comb begin
    result.op          = is_c ? c_op : std_op;
    result.rd          = is_c ? c_rd : std_rd;
    result.rs1         = is_c ? c_rs1 : std_rs1;
    result.rs2         = is_c ? c_rs2 : std_rs2;
    result.imm         = is_c ? c_imm : std_imm;
    result.pc          = entry.pc;
    result.is_c        = is_c;
    // jal target resolved here, link write left to execute
    result.jump_en     = (result.op == OP_JAL);
    result.jump_target = result.jump_en ? entry.pc + result.imm : '0;
end

endmodule

// ==== source/result_port.sv ====
`timescale 1ns/1ps

module result_port
    import rv_dec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  dec_op_t           push_data,
    output logic              full,
    input  logic              out_credit,
    output logic              out_valid,
    output op_e               out_op,
    output logic [REG_AW-1:0] out_rd,
    output logic [REG_AW-1:0] out_rs1,
    output logic [REG_AW-1:0] out_rs2,
    output logic [XLEN-1:0]   out_imm,
    output logic [XLEN-1:0]   out_pc,
    output logic              out_jump_en,
    output logic [XLEN-1:0]   out_jump_target,
    output logic              out_is_c
);

dec_op_t             head;
logic                empty;
logic                send;
logic [CREDIT_W-1:0] credits;

credit_fifo #(
    .payload_t (dec_op_t),
    .DEPTH     (OUT_DEPTH)
) out_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .pop       (send),
    .head      (head),
    .empty     (empty),
    .full      (full)
);

// send only while downstream has a free slot
assign send = !empty && (credits != '0);

always_ff @(posedge clk) begin
    if (rst) begin
        credits   <= CREDIT_W'(OUT_CREDITS);
        out_valid <= 1'b0;
    end else begin
        out_valid <= send;
        case ({send, out_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (send) begin
        out_op          <= head.op;
        out_rd          <= head.rd;
        out_rs1         <= head.rs1;
        out_rs2         <= head.rs2;
        out_imm         <= head.imm;
        out_pc          <= head.pc;
        out_jump_en     <= head.jump_en;
        out_jump_target <= head.jump_target;
        out_is_c        <= head.is_c;
    end
end

endmodule

// ==== source/rv_decode_unit.sv ====
`timescale 1ns/1ps

module rv_decode_unit
    import rv_dec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [XLEN-1:0]   in_ins,
    input  logic [XLEN-1:0]   in_pc,
    output logic              in_credit,
    input  logic              out_credit,
    output logic              out_valid,
    output op_e               out_op,
    output logic [REG_AW-1:0] out_rd,
    output logic [REG_AW-1:0] out_rs1,
    output logic [REG_AW-1:0] out_rs2,
    output logic [XLEN-1:0]   out_imm,
    output logic [XLEN-1:0]   out_pc,
    output logic              out_jump_en,
    output logic [XLEN-1:0]   out_jump_target,
    output logic              out_is_c
);

fetch_entry_t in_entry;
fetch_entry_t in_head;
logic         in_empty;
logic         in_pop;
dec_op_t      dec_result;
logic         out_full;

assign in_entry  = '{ins: in_ins, pc: in_pc};
// move one word per cycle while there is room downstream
assign in_pop    = !in_empty && !out_full;
assign in_credit = in_pop;

// upstream credits keep this queue from overflowing
credit_fifo #(
    .payload_t (fetch_entry_t),
    .DEPTH     (IN_DEPTH)
) in_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (in_valid),
    .push_data (in_entry),
    .pop       (in_pop),
    .head      (in_head),
    .empty     (in_empty),
    .full      ()
);

decode_core decode_core_i (
    .entry  (in_head),
    .result (dec_result)
);

result_port result_port_i (
    .clk             (clk),
    .rst             (rst),
    .push            (in_pop),
    .push_data       (dec_result),
    .full            (out_full),
    .out_credit      (out_credit),
    .out_valid       (out_valid),
    .out_op          (out_op),
    .out_rd          (out_rd),
    .out_rs1         (out_rs1),
    .out_rs2         (out_rs2),
    .out_imm         (out_imm),
    .out_pc          (out_pc),
    .out_jump_en     (out_jump_en),
    .out_jump_target (out_jump_target),
    .out_is_c        (out_is_c)
);

endmodule

// ==== verif/rv_decode_tb.sv ====
`timescale 1ns/1ps

module rv_decode_tb
    import rv_dec_pkg::*;
;

logic              clk;
logic              rst;
logic              in_valid;
logic [XLEN-1:0]   in_ins;
logic [XLEN-1:0]   in_pc;
logic              in_credit;
logic              out_credit;
logic              out_valid;
op_e               out_op;
logic [REG_AW-1:0] out_rd;
logic [REG_AW-1:0] out_rs1;
logic [REG_AW-1:0] out_rs2;
logic [XLEN-1:0]   out_imm;
logic [XLEN-1:0]   out_pc;
logic              out_jump_en;
logic [XLEN-1:0]   out_jump_target;
logic              out_is_c;

fetch_entry_t stim_q[$];
dec_op_t      exp_q[$];
fetch_entry_t drv_entry;
dec_op_t      cmp_exp;
int           up_credits   = IN_DEPTH;
int           held         = 0;
int           sent         = 0;
int           checked      = 0;
int           send_pct     = 80;
logic         hold_credits = 1'b0;

logic [6:0] opc_table [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                              OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};

rv_decode_unit dut_i (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (in_valid),
    .in_ins          (in_ins),
    .in_pc           (in_pc),
    .in_credit       (in_credit),
    .out_credit      (out_credit),
    .out_valid       (out_valid),
    .out_op          (out_op),
    .out_rd          (out_rd),
    .out_rs1         (out_rs1),
    .out_rs2         (out_rs2),
    .out_imm         (out_imm),
    .out_pc          (out_pc),
    .out_jump_en     (out_jump_en),
    .out_jump_target (out_jump_target),
    .out_is_c        (out_is_c)
);

always #20 clk = ~clk;

task automatic fail_run(string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
endtask

task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
        fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
endtask

function automatic logic [31:0] sext(logic [31:0] v, int top);
    sext = $signed(v << (31 - top)) >>> (31 - top);
endfunction

//////////////////////////////
// reference decode
//////////////////////////////
function automatic dec_op_t ref_std(logic [31:0] ins, dec_op_t r);
    logic [2:0]  f3;
    logic [31:0] b;
    logic [31:0] j;
    f3 = ins[14:12];
    b = '0;
    b[12] = ins[31];
    b[11] = ins[7];
    b[10:5] = ins[30:25];
    b[4:1] = ins[11:8];
    j = '0;
    j[20] = ins[31];
    j[19:12] = ins[19:12];
    j[11] = ins[20];
    j[10:1] = ins[30:21];
    r.rd  = ins[11:7];
    r.rs1 = ins[19:15];
    r.rs2 = ins[24:20];
    r.imm = sext({20'b0, ins[31:20]}, 11);
    case (ins[6:0])
        OPC_LUI, OPC_AUIPC: begin
            r.op  = (ins[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
            r.imm = ins & 32'hffff_f000;
        end
        OPC_JAL: begin
            r.op  = OP_JAL;
            r.imm = sext(j, 20);
        end
        OPC_JALR: if (f3 == 3'd0) r.op = OP_JALR;
        OPC_BRANCH: begin
            r.imm = sext(b, 12);
            case (f3)
                3'd0: r.op = OP_BEQ;
                3'd1: r.op = OP_BNE;
                3'd4: r.op = OP_BLT;
                3'd5: r.op = OP_BGE;
                3'd6: r.op = OP_BLTU;
                3'd7: r.op = OP_BGEU;
                default: ;
            endcase
        end
        OPC_LOAD: begin
            case (f3)
                3'd0: r.op = OP_LB;
                3'd1: r.op = OP_LH;
                3'd2: r.op = OP_LW;
                3'd4: r.op = OP_LBU;
                3'd5: r.op = OP_LHU;
                default: ;
            endcase
        end
        OPC_STORE: begin
            r.imm = sext({20'b0, ins[31:25], ins[11:7]}, 11);
            case (f3)
                3'd0: r.op = OP_SB;
                3'd1: r.op = OP_SH;
                3'd2: r.op = OP_SW;
                default: ;
            endcase
        end
        OPC_OP_IMM: begin
            case (f3)
                3'd0: r.op = OP_ADDI;
                3'd2: r.op = OP_SLTI;
                3'd3: r.op = OP_SLTIU;
                3'd4: r.op = OP_XORI;
                3'd6: r.op = OP_ORI;
                3'd7: r.op = OP_ANDI;
                3'd1: r.op = OP_SLLI;
                default: r.op = ins[30] ? OP_SRAI : OP_SRLI;
            endcase
            if (f3 == 3'd1 || f3 == 3'd5)
                r.imm = {27'b0, ins[24:20]};
        end
        OPC_OP: begin
            r.imm = '0;
            case (f3)
                3'd0: r.op = ins[30] ? OP_SUB : OP_ADD;
                3'd1: r.op = OP_SLL;
                3'd2: r.op = OP_SLT;
                3'd3: r.op = OP_SLTU;
                3'd4: r.op = OP_XOR;
                3'd5: r.op = ins[30] ? OP_SRA : OP_SRL;
                3'd6: r.op = OP_OR;
                default: r.op = OP_AND;
            endcase
        end
        default: ;
    endcase
    // drop the fields a format does not carry
    if (ins[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM})
        r.rs2 = '0;
    if (ins[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL})
        r.rs1 = '0;
    if (ins[6:0] inside {OPC_BRANCH, OPC_STORE})
        r.rd = '0;
    return r;
endfunction

function automatic dec_op_t ref_c(logic [15:0] c, dec_op_t r);
    logic [2:0]  f3;
    logic [4:0]  rp1;
    logic [4:0]  rp2;
    logic [31:0] ci;
    logic [31:0] u;
    logic [31:0] cj;
    logic [31:0] cb;
    f3  = c[15:13];
    rp1 = {2'b01, c[9:7]};
    rp2 = {2'b01, c[4:2]};
    ci  = sext({26'b0, c[12], c[6:2]}, 5);
    cj = '0;
    cj[11] = c[12];
    cj[4] = c[11];
    cj[9:8] = c[10:9];
    cj[10] = c[8];
    cj[6] = c[7];
    cj[7] = c[6];
    cj[3:1] = c[5:3];
    cj[5] = c[2];
    cj = sext(cj, 11);
    cb = '0;
    cb[8] = c[12];
    cb[4:3] = c[11:10];
    cb[7:6] = c[6:5];
    cb[2:1] = c[4:3];
    cb[5] = c[2];
    cb = sext(cb, 8);
    u = '0;
    if (c[1:0] == 2'b00) begin
        if (f3 == 3'd0) begin
            u[5:4] = c[12:11];
            u[9:6] = c[10:7];
            u[2] = c[6];
            u[3] = c[5];
            if (u != '0) begin
                r.op  = OP_ADDI;
                r.rd  = rp2;
                r.rs1 = 5'd2;
                r.imm = u;
            end
        end else if (f3 == 3'd2 || f3 == 3'd6) begin
            u[5:3] = c[12:10];
            u[2] = c[6];
            u[6] = c[5];
            r.op  = (f3 == 3'd2) ? OP_LW : OP_SW;
            r.rs1 = rp1;
            r.imm = u;
            if (f3 == 3'd2)
                r.rd = rp2;
            else
                r.rs2 = rp2;
        end
    end else if (c[1:0] == 2'b01) begin
        case (f3)
            3'd0, 3'd2: begin
                r.op  = OP_ADDI;
                r.rd  = c[11:7];
                r.rs1 = (f3 == 3'd0) ? c[11:7] : 5'd0;
                r.imm = ci;
            end
            3'd1, 3'd5: begin
                r.op  = OP_JAL;
                r.rd  = (f3 == 3'd1) ? 5'd1 : 5'd0;
                r.imm = cj;
            end
            3'd3: begin
                if (c[11:7] == 5'd2) begin
                    u[9] = c[12];
                    u[4] = c[6];
                    u[6] = c[5];
                    u[8:7] = c[4:3];
                    u[5] = c[2];
                    u = sext(u, 9);
                    if (u != '0) begin
                        r.op  = OP_ADDI;
                        r.rd  = 5'd2;
                        r.rs1 = 5'd2;
                        r.imm = u;
                    end
                end else if (c[11:7] != 5'd0) begin
                    u = sext({14'b0, c[12], c[6:2], 12'b0}, 17);
                    if (u != '0) begin
                        r.op  = OP_LUI;
                        r.rd  = c[11:7];
                        r.imm = u;
                    end
                end
            end
            3'd4: begin
                if (c[11:10] == 2'b10) begin
                    r.op  = OP_ANDI;
                    r.imm = ci;
                end else if (!c[12] && c[11] == 1'b0) begin
                    r.op  = c[10] ? OP_SRAI : OP_SRLI;
                    r.imm = {27'b0, c[6:2]};
                end else if (!c[12]) begin
                    r.rs2 = rp2;
                    case (c[6:5])
                        2'd0: r.op = OP_SUB;
                        2'd1: r.op = OP_XOR;
                        2'd2: r.op = OP_OR;
                        default: r.op = OP_AND;
                    endcase
                end
                if (r.op != OP_ILLEGAL) begin
                    r.rd  = rp1;
                    r.rs1 = rp1;
                end
            end
            default: begin
                r.op  = f3[0] ? OP_BNE : OP_BEQ;
                r.rs1 = rp1;
                r.imm = cb;
            end
        endcase
    end
    return r;
endfunction

function automatic dec_op_t ref_decode(logic [31:0] ins, logic [31:0] pc);
    dec_op_t r;
    r      = '0;
    r.op   = OP_ILLEGAL;
    r.is_c = (ins[1:0] != 2'b11);
    if (r.is_c)
        r = ref_c(ins[15:0], r);
    else
        r = ref_std(ins, r);
    if (r.op == OP_ILLEGAL) begin
        r.rd  = '0;
        r.rs1 = '0;
        r.rs2 = '0;
        r.imm = '0;
    end
    r.pc          = pc;
    r.jump_en     = (r.op == OP_JAL);
    r.jump_target = r.jump_en ? pc + r.imm : '0;
    return r;
endfunction

//////////////////////////////
// upstream and downstream
//////////////////////////////
always @(posedge clk) begin
    if (rst) begin
        in_valid   <= 1'b0;
        out_credit <= 1'b0;
        up_credits = IN_DEPTH;
        held       = 0;
    end else begin
        if (in_credit)
            up_credits++;
        if (up_credits > IN_DEPTH)
            fail_run("upstream got back more credits than it spent");
        if (out_valid)
            held++;
        if (held > OUT_CREDITS)
            fail_run("out_valid raised without a downstream credit");
        in_valid <= 1'b0;
        if (stim_q.size() > 0 && up_credits > 0 && int'($urandom_range(0, 99)) < send_pct) begin
            drv_entry = stim_q.pop_front();
            in_valid  <= 1'b1;
            in_ins    <= drv_entry.ins;
            in_pc     <= drv_entry.pc;
            exp_q.push_back(ref_decode(drv_entry.ins, drv_entry.pc));
            up_credits--;
            sent++;
        end
        out_credit <= 1'b0;
        if (!hold_credits && held > 0 && $urandom_range(0, 3) == 0) begin
            out_credit <= 1'b1;
            held--;
        end
    end
end

// comparator
always @(posedge clk) begin
    if (!rst && sent == 0 && (out_valid || in_credit))
        fail_run("DUT output active before any input was sent");
    if (!rst && out_valid) begin
        if (exp_q.size() == 0) begin
            fail_run("out_valid with no item outstanding");
        end else begin
            cmp_exp = exp_q.pop_front();
            check_value("out_op", 32'(out_op), 32'(cmp_exp.op));
            check_value("out_rd", 32'(out_rd), 32'(cmp_exp.rd));
            check_value("out_rs1", 32'(out_rs1), 32'(cmp_exp.rs1));
            check_value("out_rs2", 32'(out_rs2), 32'(cmp_exp.rs2));
            check_value("out_imm", out_imm, cmp_exp.imm);
            check_value("out_pc", out_pc, cmp_exp.pc);
            check_value("out_jump_en", 32'(out_jump_en), 32'(cmp_exp.jump_en));
            check_value("out_jump_target", out_jump_target, cmp_exp.jump_target);
            check_value("out_is_c", 32'(out_is_c), 32'(cmp_exp.is_c));
            checked++;
        end
    end
end

//////////////////////////////
// stimulus
//////////////////////////////
task automatic add_word(logic [31:0] ins);
    fetch_entry_t e;
    e.ins = ins;
    e.pc  = $urandom & 32'hffff_fffe;
    stim_q.push_back(e);
endtask

function automatic logic [31:0] random_word();
    logic [31:0] w;
    int          k;
    w = $urandom;
    k = int'($urandom_range(0, 9));
    if (k < 5)
        w[6:0] = opc_table[$urandom_range(0, 8)];
    else if (k < 9)
        w[1:0] = 2'($urandom_range(0, 2));
    else
        w[1:0] = 2'b11;
    return w;
endfunction

task automatic wait_drain(int limit);
    int n;
    n = 0;
    while (checked != sent || stim_q.size() != 0) begin
        @(negedge clk);
        n++;
        if (n > limit)
            fail_run("timeout while waiting for outstanding items");
    end
endtask

task automatic wait_stall(int limit);
    int n;
    n = 0;
    while (held != OUT_CREDITS || up_credits != 0) begin
        @(negedge clk);
        n++;
        if (n > limit)
            fail_run("timeout while waiting for the pipeline to fill");
    end
endtask

initial begin
    void'($urandom(32'he2a91bec));
    clk        = 1'b0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_ins     = '0;
    in_pc      = '0;
    out_credit = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // outputs must stay quiet while idle
    repeat (10) @(negedge clk);

    add_word(32'h0000_0000);
    add_word(32'h0000_8082);
    add_word(32'h0000_007f);
    add_word(32'h0080_006f);
    add_word(32'hfe00_0ee3);
    add_word(32'h4000_d093);
    add_word(32'h4020_8033);
    add_word(32'h0000_0040);
    add_word(32'h0000_2001);
    add_word(32'h0000_a001);
    add_word(32'h0000_6105);
    add_word(32'h0000_6285);
    add_word(32'h0000_0001);
    for (int i = 0; i < 60; i++)
        add_word(random_word());
    wait_drain(2000);

    // back-pressure with credits withheld
    hold_credits = 1'b1;
    send_pct     = 100;
    for (int i = 0; i < 12; i++)
        add_word(random_word());
    wait_stall(500);
    repeat (20) @(negedge clk);
    check_value("items_in_flight", 32'(sent - checked), 32'(IN_DEPTH + OUT_DEPTH));
    hold_credits = 1'b0;
    wait_drain(1000);

    // long mixed stream
    send_pct = 70;
    for (int i = 0; i < 400; i++)
        add_word(random_word());
    wait_drain(10000);

    if (checked != sent || up_credits != IN_DEPTH) begin
        fail_run("item count or upstream credit count at the end does not match");
    end else begin
        $display("RESULT: PASS");
        $finish;
    end
end

endmodule

// ==== rv_decode.f ====
common/rv_dec_pkg.sv
source/credit_fifo.sv
decode/std_decoder.sv
decode/c_decoder.sv
decode/decode_core.sv
source/result_port.sv
source/rv_decode_unit.sv
verif/rv_decode_tb.sv

// ==== Makefile ====
TOP       ?= rv_decode_tb
FILELIST  ?= rv_decode.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)
